// ==== Makefile ====
TOP := tb_writeback_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/10ps --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -Mdir obj_dir \
		--top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
+incdir+hdl
hdl/wbq_pkg.sv
hdl/victim_capture.sv
hdl/replace_queue.sv
hdl/line_writeback.sv
hdl/writeback_top.sv
test/axi_wr_responder.sv
test/tb_writeback_top.sv

// ==== hdl/line_writeback.sv ====
`timescale 1ns/10ps
`include "wbq_config.svh"

module line_writeback import wbq_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      head_valid,
    input  wb_entry_t head,
    output logic      pop,
    output logic      aw_valid,
    output axi_aw_t   aw,
    input  logic      aw_ready,
    output logic      w_valid,
    output axi_w_t    w,
    input  logic      w_ready,
    input  logic      b_valid
);

    localparam int cnt_width = $clog2(`WBQ_LINE_BEATS);
    localparam logic [cnt_width-1:0] last_beat = cnt_width'(`WBQ_LINE_BEATS - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_data,
        st_resp,
        st_retire
    } wb_state_t;

    wb_state_t            state;
    wb_entry_t            work; // copy of the head being written out
    logic [cnt_width-1:0] beat_idx;
    logic                 b_ready;

    assign b_ready = 1'b1; // responses are always taken
    assign pop     = (state == st_retire);

    //////////////////////////////////////////////////////////////
    // write master FSM
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            beat_idx <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (head_valid) begin
                        aw_valid <= 1'b1;
                        state    <= st_addr;
                    end
                end
                st_addr: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                        beat_idx <= '0;
                        if (work.dirty) begin
                            w_valid <= 1'b1;
                            state   <= st_data;
                        end else begin
                            state <= st_resp; // evict notice carries no data
                        end
                    end
                end
                st_data: begin
                    if (w_ready) begin
                        if (beat_idx == last_beat) begin
                            w_valid <= 1'b0;
                            state   <= st_resp;
                        end else begin
                            beat_idx <= beat_idx + 1'b1;
                        end
                    end
                end
                st_resp: begin
                    if (b_valid && b_ready) begin
                        state <= st_retire;
                    end
                end
                default: begin
                    state <= st_idle; // retire lasts a single cycle
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && head_valid) begin
            work <= head;
        end
    end

    //////////////////////////////////////////////////////////////
    // channel payloads
    //////////////////////////////////////////////////////////////

    assign aw.addr  = {work.addr, {`WBQ_LINE_OFFSET_BITS{1'b0}}};
    assign aw.len   = work.dirty ? 8'(`WBQ_LINE_BEATS - 1) : 8'd0;
    assign aw.size  = 3'($clog2(`WBQ_BEAT_BYTES));
    assign aw.burst = AXI_BURST_INCR;
    assign aw.user  = work.dirty;

    assign w.data = work.data[beat_idx];
    assign w.strb = '1;
    assign w.last = (beat_idx == last_beat);

    a_aw_stable: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw));

    a_w_stable: assert property (@(posedge clk) disable iff (rst)
        w_valid && !w_ready |=> w_valid && $stable(w));

endmodule

// ==== hdl/replace_queue.sv ====
`timescale 1ns/10ps
`include "wbq_config.svh"

module replace_queue import wbq_pkg::*; #(
    parameter int depth = `WBQ_DEPTH
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  wb_entry_t   push_entry,
    output logic        full,
    output logic        head_valid,
    output wb_entry_t   head,
    input  logic        pop,
    input  line_addr_t  lookup_addr,
    output lookup_rsp_t lookup_rsp
);

    localparam int ptr_width = $clog2(depth);

    wb_entry_t            mem [depth];
    logic [depth-1:0]     vld;
    logic [ptr_width-1:0] head_ptr;
    logic [ptr_width-1:0] tail_ptr;
    logic [ptr_width-1:0] scan_idx;
    logic                 match_hit;
    line_t                match_data;
    logic                 rsp_hit;
    line_t                rsp_data;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full       = &vld;
    assign head_valid = vld[head_ptr];
    assign head       = mem[head_ptr];

    //////////////////////////////////////////////////////////////
    // ring storage
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld      <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (push) begin
                vld[tail_ptr] <= 1'b1;
                tail_ptr      <= next_ptr(tail_ptr);
            end
            if (pop) begin
                vld[head_ptr] <= 1'b0;
                head_ptr      <= next_ptr(head_ptr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail_ptr] <= push_entry;
        end
    end

    //////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////

    // The scan walks from oldest to newest so a later match overrides an
    // earlier one. The result shows the queue as it stands after the
    // edge, so an entry leaving on pop is skipped and one arriving on
    // push is already seen.
    always_comb begin
        match_hit  = 1'b0;
        match_data = '0;
        scan_idx   = head_ptr;
        for (int i = 0; i < depth; i++) begin
            if (vld[scan_idx] && !(pop && scan_idx == head_ptr) &&
                mem[scan_idx].addr == lookup_addr) begin
                match_hit  = 1'b1;
                match_data = mem[scan_idx].data;
            end
            scan_idx = next_ptr(scan_idx);
        end
        if (push && push_entry.addr == lookup_addr) begin
            match_hit  = 1'b1; // newest of all
            match_data = push_entry.data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_hit <= 1'b0;
        end else begin
            rsp_hit <= match_hit;
        end
    end

    always_ff @(posedge clk) begin
        rsp_data <= match_data;
    end

    assign lookup_rsp = '{hit: rsp_hit, data: rsp_data};

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> !full);

    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> head_valid);

endmodule

// ==== hdl/victim_capture.sv ====
`timescale 1ns/10ps
`include "wbq_config.svh"

module victim_capture import wbq_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         evict_en,
    input  victim_info_t victim,
    input  logic         beat_en,
    input  beat_t        beat,
    output logic         evict_ready,
    input  logic         full,
    output logic         push,
    output wb_entry_t    push_entry
);

    localparam int cnt_width = $clog2(`WBQ_LINE_BEATS);
    localparam logic [cnt_width-1:0] last_beat = cnt_width'(`WBQ_LINE_BEATS - 1);

    logic                 busy; // a dirty line is still streaming in
    logic [cnt_width-1:0] beat_cnt;
    logic                 line_done;
    victim_info_t         info;
    line_t                line_buf;

    assign line_done = busy && beat_en && (beat_cnt == last_beat);

    // one victim at a time, and not while the push of the previous one
    // is still on its way into the queue
    assign evict_ready = !busy && !push && !full;

    //////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            beat_cnt <= '0;
            push     <= 1'b0;
        end else begin
            push <= (evict_en && !victim.dirty) || line_done; // clean lines go out at once
            if (evict_en && victim.dirty) begin
                busy     <= 1'b1;
                beat_cnt <= '0;
            end else if (busy && beat_en) begin
                beat_cnt <= beat_cnt + 1'b1; // wraps back to zero on the last beat
                if (line_done) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // line assembly
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (evict_en) begin
            info <= victim;
        end
        if (busy && beat_en) begin
            line_buf[beat_cnt] <= beat;
        end
    end

    assign push_entry = '{addr: info.addr, dirty: info.dirty, data: line_buf};

    // beats belong to a dirty victim that was announced first
    a_no_stray_beat: assert property (@(posedge clk) disable iff (rst) beat_en |-> busy);

    a_evict_when_ready: assert property (@(posedge clk) disable iff (rst)
        evict_en |-> evict_ready);

endmodule

// ==== hdl/wbq_config.svh ====
`ifndef WBQ_CONFIG_SVH
`define WBQ_CONFIG_SVH

//////////////////////////////////////////////////////////////
// address and line geometry
//////////////////////////////////////////////////////////////

`define WBQ_ADDR_WIDTH 32

`define WBQ_LINE_BYTES 32 // 16 and 64 are also supported

`define WBQ_BEAT_BYTES 4

`define WBQ_LINE_BEATS (`WBQ_LINE_BYTES / `WBQ_BEAT_BYTES)

// byte offset inside a line, dropped from the stored address
`define WBQ_LINE_OFFSET_BITS $clog2(`WBQ_LINE_BYTES)

`define WBQ_LINE_ADDR_WIDTH (`WBQ_ADDR_WIDTH - `WBQ_LINE_OFFSET_BITS)

// write-back queue entries, 2 and 8 also work
`define WBQ_DEPTH 4

`endif

// ==== hdl/wbq_pkg.sv ====
`include "wbq_config.svh"

package wbq_pkg;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    typedef logic [`WBQ_LINE_ADDR_WIDTH-1:0] line_addr_t;

    typedef logic [8*`WBQ_BEAT_BYTES-1:0] beat_t;

    // beat 0 sits at the low end of the line
    typedef beat_t [`WBQ_LINE_BEATS-1:0] line_t;

    typedef struct packed {
        line_addr_t addr;
        logic       dirty;
    } victim_info_t;

    typedef struct packed {
        line_addr_t addr;
        logic       dirty;
        line_t      data;
    } wb_entry_t;

    typedef struct packed {
        logic [`WBQ_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        logic [1:0]                 burst;
        logic                       user; // dirty flag of the line
    } axi_aw_t;

    typedef struct packed {
        beat_t                      data;
        logic [`WBQ_BEAT_BYTES-1:0] strb;
        logic                       last;
    } axi_w_t;

    typedef struct packed {
        logic  hit;
        line_t data;
    } lookup_rsp_t;

endpackage

// ==== hdl/writeback_top.sv ====
`timescale 1ns/10ps

module writeback_top import wbq_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         evict_en,
    input  victim_info_t victim,
    input  logic         beat_en,
    input  beat_t        beat,
    output logic         evict_ready,
    input  line_addr_t   lookup_addr,
    output lookup_rsp_t  lookup_rsp,
    output logic         aw_valid,
    output axi_aw_t      aw,
    input  logic         aw_ready,
    output logic         w_valid,
    output axi_w_t       w,
    input  logic         w_ready,
    input  logic         b_valid
);

    logic      push;
    wb_entry_t push_entry;
    logic      full;
    logic      head_valid;
    wb_entry_t head;
    logic      pop;

    //////////////////////////////////////////////////////////////
    // victim in, queue, AXI write out
    //////////////////////////////////////////////////////////////

    victim_capture u_victim_capture (
        .clk, .rst, .evict_en, .victim, .beat_en, .beat, .evict_ready,
        .full, .push, .push_entry
    );

    replace_queue u_replace_queue (
        .clk, .rst, .push, .push_entry, .full, .head_valid, .head, .pop,
        .lookup_addr, .lookup_rsp
    );

    line_writeback u_line_writeback (
        .clk, .rst, .head_valid, .head, .pop,
        .aw_valid, .aw, .aw_ready,
        .w_valid, .w, .w_ready,
        .b_valid
    );

endmodule

// ==== test/axi_wr_responder.sv ====
`timescale 1ns/10ps
`include "wbq_config.svh"

module axi_wr_responder import wbq_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        aw_hold,    // keeps aw_ready low while set
    input  logic [31:0] w_gap_mask, // w_ready pattern, one bit per cycle
    input  logic        aw_valid,
    input  axi_aw_t     aw,
    output logic        aw_ready,
    input  logic        w_valid,
    input  axi_w_t      w,
    output logic        w_ready,
    output logic        b_valid
);

    axi_aw_t     aw_log[$];
    axi_w_t      w_log[$];
    int          b_count = 0;
    logic        b_due = 1'b0;
    logic [31:0] gap_mask_q = '1;
    logic [4:0]  gap_idx;

    assign aw_ready = !aw_hold;

    always @(posedge clk) begin
        gap_mask_q <= w_gap_mask;
        b_due      <= 1'b0;
        if (!rst) begin
            if (aw_valid && aw_ready) begin
                aw_log.push_back(aw);
                if (!aw.user) begin
                    b_due <= 1'b1; // an evict notice has no data phase
                end
            end
            if (w_valid && w_ready) begin
                w_log.push_back(w);
                if (w.last) begin
                    b_due <= 1'b1;
                end
            end
            if (b_valid) begin
                b_count++; // the DUT holds b_ready high
            end
        end
    end

    // ready and response lines change on the falling edge only
    initial begin
        w_ready = 1'b0;
        b_valid = 1'b0;
        gap_idx = '0;
        forever begin
            @(negedge clk);
            w_ready = gap_mask_q[gap_idx];
            gap_idx = gap_idx + 5'd1;
            b_valid = b_due;
        end
    end

endmodule

// ==== test/tb_writeback_top.sv ====
`timescale 1ns/10ps
`include "wbq_config.svh"

module tb_writeback_top import wbq_pkg::*; ();

    // dirty, clean, ordering, lookup and stall tests
    localparam int n_lines     = 2 + (`WBQ_DEPTH + 1) + 2 + 2;
    localparam int cycle_limit = 40 * n_lines + 300;

    logic         clk;
    logic         rst;
    logic         evict_en;
    victim_info_t victim;
    logic         beat_en;
    beat_t        beat;
    logic         evict_ready;
    line_addr_t   lookup_addr;
    lookup_rsp_t  lookup_rsp;
    logic         aw_valid;
    axi_aw_t      aw;
    logic         aw_ready;
    logic         w_valid;
    axi_w_t       w;
    logic         w_ready;
    logic         b_valid;
    logic         aw_hold;
    logic [31:0]  w_gap_mask;

    axi_aw_t exp_aw_q[$];
    beat_t   exp_beat_q[$];
    int      lines_sent = 0;
    int      fail_count = 0;
    int      test_count = 0;
    int      cycle_count = 0;

    writeback_top u_writeback_top (.*);

    axi_wr_responder responder (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the write-back never completed", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_aw(input string name, input axi_aw_t got, input axi_aw_t exp);
        if (got !== exp) begin
            $write("[FAIL] %0t %s: got addr %h len %0d size %0d burst %b user %b",
                   $time, name, got.addr, got.len, got.size, got.burst, got.user);
            $display(", expected addr %h len %0d size %0d burst %b user %b",
                     exp.addr, exp.len, exp.size, exp.burst, exp.user);
            fail_count++;
        end
    endtask

    task automatic check_beat(input string name, input beat_t got, input beat_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
            fail_count++;
        end
    endtask

    task automatic check_lookup(input string name, input lookup_rsp_t got, input lookup_rsp_t exp);
        if (got.hit !== exp.hit) begin
            $display("[FAIL] %0t %s.hit: got %b, expected %b", $time, name, got.hit, exp.hit);
            fail_count++;
        end else if (exp.hit && got.data !== exp.data) begin
            $display("[FAIL] %0t %s.data: got %h, expected %h", $time, name, got.data, exp.data);
            fail_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
            fail_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    function automatic line_t random_line();
        line_t data;
        for (int i = 0; i < `WBQ_LINE_BEATS; i++) begin
            data[i] = $urandom;
        end
        return data;
    endfunction

    // AXI size code, the power of two that gives the bytes in one beat
    function automatic logic [2:0] size_code(input int bytes);
        for (int s = 0; s < 8; s++) begin
            if ((1 << s) == bytes) begin
                return 3'(s);
            end
        end
        return 3'd7;
    endfunction

    // announces one victim and streams its beats, then queues what the bus should show
    task automatic offer_victim(input line_addr_t addr, input logic dirty, input line_t data);
        axi_aw_t                    exp;
        logic [`WBQ_ADDR_WIDTH-1:0] byte_addr;
        int                         n_beats;
        n_beats = 0;
        @(negedge clk);
        while (!evict_ready) begin
            @(negedge clk);
        end
        evict_en = 1'b1;
        victim   = '{addr: addr, dirty: dirty};
        @(negedge clk);
        evict_en = 1'b0;
        if (dirty) begin
            for (int i = 0; i < `WBQ_LINE_BEATS; i++) begin
                if ($urandom_range(3) == 0) begin
                    @(negedge clk); // idle gap between beats
                end
                beat_en = 1'b1;
                beat    = data[i];
                exp_beat_q.push_back(data[i]);
                n_beats++;
                @(negedge clk);
                beat_en = 1'b0;
            end
        end
        byte_addr = {{(`WBQ_ADDR_WIDTH - `WBQ_LINE_ADDR_WIDTH){1'b0}}, addr};
        exp.addr  = byte_addr * `WBQ_LINE_BYTES;
        exp.len   = dirty ? 8'(n_beats - 1) : 8'd0;
        exp.size  = size_code(`WBQ_BEAT_BYTES);
        exp.burst = 2'b01; // INCR
        exp.user  = dirty;
        exp_aw_q.push_back(exp);
        lines_sent++;
    endtask

    // waits for every B response, then compares the recorded AW and W traffic
    task automatic check_writes();
        axi_w_t got_w;
        int     idx;
        while (responder.b_count < lines_sent) begin
            @(negedge clk);
        end
        if (responder.aw_log.size() != exp_aw_q.size() ||
            responder.w_log.size() != exp_beat_q.size()) begin
            $display("%0t wrong transfer count: %0d AW and %0d W seen, %0d and %0d expected",
                     $time, responder.aw_log.size(), responder.w_log.size(),
                     exp_aw_q.size(), exp_beat_q.size());
            fail_count++;
        end
        while (exp_aw_q.size() > 0 && responder.aw_log.size() > 0) begin
            check_aw("aw", responder.aw_log.pop_front(), exp_aw_q.pop_front());
        end
        idx = 0;
        while (exp_beat_q.size() > 0 && responder.w_log.size() > 0) begin
            got_w = responder.w_log.pop_front();
            check_beat("w.data", got_w.data, exp_beat_q.pop_front());
            check_flag("w.last", got_w.last, (idx % `WBQ_LINE_BEATS) == `WBQ_LINE_BEATS - 1);
            check_flag("&w.strb", &got_w.strb, 1'b1);
            idx++;
        end
        exp_aw_q.delete();
        exp_beat_q.delete();
        responder.aw_log.delete();
        responder.w_log.delete();
    endtask

    task automatic report_test(input string name, input int start_fails);
        test_count++;
        if (fail_count == start_fails) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, fail_count - start_fails);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int          start_fails;
        lookup_rsp_t miss;
        start_fails = fail_count;
        miss        = '{hit: 1'b0, data: '0};
        check_flag("aw_valid", aw_valid, 1'b0);
        check_flag("w_valid", w_valid, 1'b0);
        check_flag("evict_ready", evict_ready, 1'b1);
        check_lookup("lookup_rsp", lookup_rsp, miss);
        report_test("reset state", start_fails);
    endtask

    task automatic test_single(input string name, input logic dirty);
        int start_fails;
        start_fails = fail_count;
        offer_victim(line_addr_t'($urandom), dirty, random_line());
        check_writes();
        report_test(name, start_fails);
    endtask

    task automatic test_ordering();
        int         start_fails;
        line_addr_t base;
        start_fails = fail_count;
        base        = line_addr_t'($urandom);
        aw_hold     = 1'b1;
        for (int n = 0; n < `WBQ_DEPTH; n++) begin
            offer_victim(base ^ line_addr_t'(n), (n % 2) == 0, random_line());
        end
        repeat (8) begin
            @(negedge clk);
            check_flag("evict_ready", evict_ready, 1'b0); // queue is full
        end
        aw_hold = 1'b0;
        offer_victim(base ^ line_addr_t'(`WBQ_DEPTH), 1'b1, random_line());
        check_writes();
        report_test("ordering under back-pressure", start_fails);
    endtask

    task automatic test_lookup();
        int          start_fails;
        line_addr_t  addr;
        line_t       data;
        lookup_rsp_t exp;
        start_fails = fail_count;
        addr        = line_addr_t'($urandom);
        data        = random_line();
        aw_hold     = 1'b1;
        offer_victim(addr, 1'b1, data);
        offer_victim(addr ^ line_addr_t'(1), 1'b1, random_line());
        lookup_addr = addr;
        @(negedge clk);
        exp = '{hit: 1'b1, data: data};
        check_lookup("lookup_rsp", lookup_rsp, exp);
        lookup_addr = addr ^ line_addr_t'(2);
        @(negedge clk);
        exp = '{hit: 1'b0, data: '0};
        check_lookup("lookup_rsp", lookup_rsp, exp);
        lookup_addr = addr;
        aw_hold     = 1'b0;
        while (responder.b_count < lines_sent - 1) begin
            @(negedge clk);
        end
        exp = '{hit: 1'b1, data: data};
        check_lookup("lookup_rsp", lookup_rsp, exp); // still queued until the retire
        @(negedge clk); // the retired line is gone one cycle after its B
        exp = '{hit: 1'b0, data: '0};
        check_lookup("lookup_rsp", lookup_rsp, exp);
        check_writes();
        report_test("lookup", start_fails);
    endtask

    task automatic test_w_stalls();
        int start_fails;
        start_fails = fail_count;
        w_gap_mask  = $urandom | 32'h8888_8888;
        offer_victim(line_addr_t'($urandom), 1'b1, random_line());
        offer_victim(line_addr_t'($urandom), 1'b1, random_line());
        check_writes();
        w_gap_mask = '1;
        report_test("W stalls", start_fails);
    endtask

    initial begin
        void'($urandom(32'hb1581ee9));
        rst         = 1'b1;
        evict_en    = 1'b0;
        victim      = '0;
        beat_en     = 1'b0;
        beat        = '0;
        lookup_addr = '0;
        aw_hold     = 1'b0;
        w_gap_mask  = '1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_single("dirty eviction", 1'b1);
        test_single("clean eviction", 1'b0);
        test_ordering();
        test_lookup();
        test_w_stalls();
        $display("%0d tests run, %0d errors", test_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
